// File: design/pwm_pkg.sv
// Bus, register and counter types, register map and front-end FSM states
`default_nettype none

package pwm_pkg;

  ////////////////////////////////////////////////
  // AXI4-Lite bus types
  ////////////////////////////////////////////////

  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [3:0]  axil_strb_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  ////////////////////////////////////////////////
  // PWM channel registers
  ////////////////////////////////////////////////

  localparam int unsigned PwmCtrSize = 8;

  typedef logic [PwmCtrSize-1:0] pwm_cnt_t; // Counter, duty and period
  typedef logic [1:0]            reg_sel_t;
  typedef logic [3:0]            chan_idx_t;

  // Address fields
  localparam int unsigned RegSelLsb  = 2; // Register index in bits 3:2
  localparam int unsigned ChanIdxLsb = 4; // Channel index in bits 7:4

  localparam reg_sel_t REG_DUTY   = 2'd0;
  localparam reg_sel_t REG_PERIOD = 2'd1;
  localparam reg_sel_t REG_CTRL   = 2'd2; // Index 3 left unmapped

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    WAIT_RSP,
    RESP
  } frontend_state_e;

endpackage

`default_nettype wire

// File: design/pwm_reg_if.sv
// Per-channel register access and reply signals with their modports
`timescale 1ns/1ps
`default_nettype none

interface pwm_reg_if import pwm_pkg::*; ();

  // Request side, from the front end
  logic       req;   // Single-cycle access strobe
  logic       we;    // Write when set, read otherwise
  reg_sel_t   sel;
  pwm_cnt_t   wdata;
  logic       wen;   // Strobe bit 0

  // Reply side, from the channel
  axil_data_t rdata; // Combinational from sel
  logic       err;   // Unmapped register index

  modport frontend (
    output req, we, sel, wdata, wen
  );

  modport channel (
    input  req, we, sel, wdata, wen,
    output rdata, err
  );

  modport collect (
    input req, rdata, err
  );

endinterface

`default_nettype wire

// File: design/pwm_channel.sv
// PWM channel with duty, period and enable registers, counter and output compare
`timescale 1ns/1ps
`default_nettype none

module pwm_channel import pwm_pkg::*; (
  input  logic       clk_sys_i,
  input  logic       rst_sys_ni,
  pwm_reg_if.channel reg_if,
  output logic       pwm_o
);

  pwm_cnt_t duty_q;
  pwm_cnt_t period_q;
  pwm_cnt_t cnt_q;
  logic     en_q;   // CTRL bit 0
  logic     wr_en;

  //////////////////////////////////////////////////
  // Register access
  //////////////////////////////////////////////////

  assign wr_en = reg_if.req & reg_if.we & reg_if.wen;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      duty_q   <= '0;
      period_q <= '0;
      en_q     <= 1'b0;
    end else if (wr_en) begin
      unique case (reg_if.sel)
        REG_DUTY:   duty_q   <= reg_if.wdata;
        REG_PERIOD: period_q <= reg_if.wdata;
        REG_CTRL:   en_q     <= reg_if.wdata[0];
        default: ;  // Unmapped, nothing changes
      endcase
    end
  end

  always_comb begin
    unique case (reg_if.sel)
      REG_DUTY:   reg_if.rdata = axil_data_t'(duty_q);
      REG_PERIOD: reg_if.rdata = axil_data_t'(period_q);
      REG_CTRL:   reg_if.rdata = axil_data_t'(en_q);
      default:    reg_if.rdata = '0;
    endcase
  end

  assign reg_if.err = !(reg_if.sel inside {REG_DUTY, REG_PERIOD, REG_CTRL});

  //////////////////////////////////////////////////
  // Counter and compare
  //////////////////////////////////////////////////

  // Runs 0..PERIOD, so one period lasts PERIOD+1 cycles
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      cnt_q <= '0;
    end else if (!en_q || (cnt_q >= period_q)) begin
      cnt_q <= '0; // Also recovers when PERIOD drops below the count
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign pwm_o = en_q & (cnt_q < duty_q);

endmodule

`default_nettype wire

// File: design/pwm_rsp_collect.sv
// Response collector registering the addressed channel's reply or an error
`timescale 1ns/1ps
`default_nettype none

module pwm_rsp_collect import pwm_pkg::*; #(
  parameter int unsigned NumChannels = 4
) (
  input  logic       clk_sys_i,
  input  logic       rst_sys_ni,
  pwm_reg_if.collect regs_i [NumChannels],
  input  logic       access_i,
  output logic       rsp_valid_o,
  output axil_data_t rsp_data_o,
  output logic       rsp_err_o
);

  logic [NumChannels-1:0] req_vec;
  logic [NumChannels-1:0] err_vec;
  axil_data_t             rdata_arr [NumChannels];
  axil_data_t             sel_data;
  logic                   sel_err;

  for (genvar i = 0; i < NumChannels; i++) begin : gen_gather
    assign req_vec[i]   = regs_i[i].req;
    assign err_vec[i]   = regs_i[i].err;
    assign rdata_arr[i] = regs_i[i].rdata;
  end

  // Reply of the channel whose req is high
  always_comb begin
    sel_data = '0;
    sel_err  = 1'b1; // No channel addressed
    for (int i = 0; i < NumChannels; i++) begin
      if (req_vec[i]) begin
        sel_data = rdata_arr[i];
        sel_err  = err_vec[i];
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= access_i;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (access_i) begin
      rsp_data_o <= sel_data;
      rsp_err_o  <= sel_err;
    end
  end

  // Channel requests only come inside a front-end access cycle
  a_req_in_access: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    (|req_vec) |-> access_i);

endmodule

`default_nettype wire

// File: design/pwm_axil_frontend.sv
// AXI4-Lite slave FSM, request latching and channel address decode
`timescale 1ns/1ps
`default_nettype none

module pwm_axil_frontend import pwm_pkg::*; #(
  parameter int unsigned NumChannels = 4
) (
  input  logic        clk_sys_i,
  input  logic        rst_sys_ni,

  // AXI4-Lite slave
  input  logic        s_axil_awvalid_i,
  output logic        s_axil_awready_o,
  input  axil_addr_t  s_axil_awaddr_i,
  input  logic        s_axil_wvalid_i,
  output logic        s_axil_wready_o,
  input  axil_data_t  s_axil_wdata_i,
  input  axil_strb_t  s_axil_wstrb_i,
  output logic        s_axil_bvalid_o,
  input  logic        s_axil_bready_i,
  output axil_resp_t  s_axil_bresp_o,
  input  logic        s_axil_arvalid_i,
  output logic        s_axil_arready_o,
  input  axil_addr_t  s_axil_araddr_i,
  output logic        s_axil_rvalid_o,
  input  logic        s_axil_rready_i,
  output axil_data_t  s_axil_rdata_o,
  output axil_resp_t  s_axil_rresp_o,

  // Channel requests
  pwm_reg_if.frontend regs_o [NumChannels],

  // Reply from the collector
  output logic        access_o,
  input  logic        rsp_valid_i,
  input  axil_data_t  rsp_data_i,
  input  logic        rsp_err_i
);

  frontend_state_e        state_q, state_d;
  logic                   we_q;
  chan_idx_t              chan_q;
  reg_sel_t               sel_q;
  pwm_cnt_t               wdata_q;
  logic                   wen_q;
  axil_data_t             rdata_q;
  axil_resp_t             resp_q;
  logic                   wr_take;
  logic                   rd_take;
  logic                   chan_hit;
  logic [NumChannels-1:0] req_vec;

  //////////////////////////////////////////////////
  // Address acceptance and FSM
  //////////////////////////////////////////////////

  assign wr_take = (state_q == IDLE) & s_axil_awvalid_i & s_axil_wvalid_i;
  assign rd_take = (state_q == IDLE) & s_axil_arvalid_i & ~wr_take; // Write wins a tie

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (wr_take || rd_take) begin
          state_d = ACCESS;
        end
      end
      ACCESS:   state_d = WAIT_RSP;
      WAIT_RSP: begin
        if (rsp_valid_i) begin
          state_d = RESP;
        end
      end
      RESP: begin
        // Hold until the host takes the response
        if (we_q ? s_axil_bready_i : s_axil_rready_i) begin
          state_d = IDLE;
        end
      end
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      state_q <= IDLE;
      we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wr_take || rd_take) begin
        we_q <= wr_take;
      end
    end
  end

  // Request fields and response payload
  always_ff @(posedge clk_sys_i) begin
    if (wr_take) begin
      chan_q  <= s_axil_awaddr_i[ChanIdxLsb +: $bits(chan_idx_t)];
      sel_q   <= s_axil_awaddr_i[RegSelLsb +: $bits(reg_sel_t)];
      wdata_q <= s_axil_wdata_i[PwmCtrSize-1:0]; // Registers are 8 bits wide
      wen_q   <= s_axil_wstrb_i[0];
    end else if (rd_take) begin
      chan_q  <= s_axil_araddr_i[ChanIdxLsb +: $bits(chan_idx_t)];
      sel_q   <= s_axil_araddr_i[RegSelLsb +: $bits(reg_sel_t)];
    end
    if ((state_q == WAIT_RSP) && rsp_valid_i) begin
      rdata_q <= rsp_data_i;
      resp_q  <= rsp_err_i ? RESP_SLVERR : RESP_OKAY;
    end
  end

  //////////////////////////////////////////////////
  // Channel decode
  //////////////////////////////////////////////////

  assign access_o = (state_q == ACCESS);
  assign chan_hit = (chan_q < NumChannels); // Out of range gets no req

  for (genvar i = 0; i < NumChannels; i++) begin : gen_req
    assign req_vec[i]      = access_o & chan_hit & (chan_q == chan_idx_t'(i));
    assign regs_o[i].req   = req_vec[i];
    assign regs_o[i].we    = we_q;
    assign regs_o[i].sel   = sel_q;
    assign regs_o[i].wdata = wdata_q;
    assign regs_o[i].wen   = wen_q;
  end

  assign s_axil_awready_o = wr_take;
  assign s_axil_wready_o  = wr_take;
  assign s_axil_arready_o = rd_take;
  assign s_axil_bvalid_o  = (state_q == RESP) & we_q;
  assign s_axil_rvalid_o  = (state_q == RESP) & ~we_q;
  assign s_axil_bresp_o   = resp_q;
  assign s_axil_rresp_o   = resp_q;
  assign s_axil_rdata_o   = rdata_q;

  // Stalled response keeps its payload
  a_b_hold: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o && $stable(s_axil_bresp_o));

  a_r_hold: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    s_axil_rvalid_o && !s_axil_rready_i |=>
      s_axil_rvalid_o && $stable(s_axil_rdata_o) && $stable(s_axil_rresp_o));

endmodule

`default_nettype wire

// File: design/pwm_subsystem.sv
// Top level with AXI4-Lite ports, front end, PWM channel array and response collector
`timescale 1ns/1ps
`default_nettype none

module pwm_subsystem import pwm_pkg::*; #(
  parameter int unsigned NumChannels = 4 // 1 to 16
) (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,

  // AXI4-Lite slave
  input  logic                   s_axil_awvalid_i,
  output logic                   s_axil_awready_o,
  input  axil_addr_t             s_axil_awaddr_i,
  input  logic                   s_axil_wvalid_i,
  output logic                   s_axil_wready_o,
  input  axil_data_t             s_axil_wdata_i,
  input  axil_strb_t             s_axil_wstrb_i,
  output logic                   s_axil_bvalid_o,
  input  logic                   s_axil_bready_i,
  output axil_resp_t             s_axil_bresp_o,
  input  logic                   s_axil_arvalid_i,
  output logic                   s_axil_arready_o,
  input  axil_addr_t             s_axil_araddr_i,
  output logic                   s_axil_rvalid_o,
  input  logic                   s_axil_rready_i,
  output axil_data_t             s_axil_rdata_o,
  output axil_resp_t             s_axil_rresp_o,

  output logic [NumChannels-1:0] pwm_o
);

  logic       access;
  logic       rsp_valid;
  axil_data_t rsp_data;
  logic       rsp_err;

  pwm_reg_if reg_if [NumChannels] ();

  pwm_axil_frontend #(
    .NumChannels ( NumChannels )
  ) u_frontend (
    .clk_sys_i,
    .rst_sys_ni,
    .s_axil_awvalid_i,
    .s_axil_awready_o,
    .s_axil_awaddr_i,
    .s_axil_wvalid_i,
    .s_axil_wready_o,
    .s_axil_wdata_i,
    .s_axil_wstrb_i,
    .s_axil_bvalid_o,
    .s_axil_bready_i,
    .s_axil_bresp_o,
    .s_axil_arvalid_i,
    .s_axil_arready_o,
    .s_axil_araddr_i,
    .s_axil_rvalid_o,
    .s_axil_rready_i,
    .s_axil_rdata_o,
    .s_axil_rresp_o,
    .regs_o      (reg_if),
    .access_o    (access),
    .rsp_valid_i (rsp_valid),
    .rsp_data_i  (rsp_data),
    .rsp_err_i   (rsp_err)
  );

  for (genvar i = 0; i < NumChannels; i++) begin : gen_chan
    pwm_channel u_chan (
      .clk_sys_i,
      .rst_sys_ni,
      .reg_if (reg_if[i]),
      .pwm_o  (pwm_o[i])
    );
  end

  pwm_rsp_collect #(
    .NumChannels ( NumChannels )
  ) u_collect (
    .clk_sys_i,
    .rst_sys_ni,
    .regs_i      (reg_if),
    .access_i    (access),
    .rsp_valid_o (rsp_valid),
    .rsp_data_o  (rsp_data),
    .rsp_err_o   (rsp_err)
  );

endmodule

`default_nettype wire

// File: bench/tb_pwm_subsystem.sv
// Testbench for the PWM subsystem with bus tasks, reference model, checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_pwm_subsystem import pwm_pkg::*; ();

  localparam int unsigned NumChannels = 4;
  localparam int unsigned ClkPeriod   = 100;
  localparam int unsigned MaxStall    = 8;
  localparam int unsigned PwmPeriods  = 2; // Periods per PWM window
  localparam int unsigned NumTxn      = NumChannels * (NumChannels + 16) + 60;
  localparam int unsigned TimeoutCyc  = 2 * (NumTxn * (20 + MaxStall)
                                        + NumChannels * PwmPeriods * 256) + 100;

  logic                   clk_sys, rst_sys_n;
  logic                   awvalid, awready, wvalid, wready, bvalid, bready;
  logic                   arvalid, arready, rvalid, rready;
  axil_addr_t             awaddr, araddr;
  axil_data_t             wdata, rdata;
  axil_strb_t             wstrb;
  axil_resp_t             bresp, rresp;
  logic [NumChannels-1:0] pwm;

  // Shadow registers and expected responses
  pwm_cnt_t   duty_m [NumChannels];
  pwm_cnt_t   period_m [NumChannels];
  logic       ctrl_m [NumChannels];
  axil_data_t exp_rdata_q [$];
  axil_resp_t exp_rresp_q [$];
  axil_resp_t exp_bresp_q [$];
  logic       r_held = 1'b0;
  logic       b_held = 1'b0;
  axil_data_t r_data_h;
  axil_resp_t r_resp_h, b_resp_h;

  pwm_subsystem #(
    .NumChannels ( NumChannels )
  ) dut (
    .clk_sys_i        (clk_sys),
    .rst_sys_ni       (rst_sys_n),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_bresp_o   (bresp),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_araddr_i  (araddr),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .pwm_o            (pwm)
  );

  initial begin
    clk_sys = 1'b0;
    forever #(ClkPeriod / 2) clk_sys = ~clk_sys;
  end

  initial begin
    #(longint'(TimeoutCyc) * ClkPeriod);
    fail_run("Timeout: the run did not finish within the expected number of cycles");
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic axil_addr_t reg_addr(input int unsigned chan, input reg_sel_t sel);
    reg_addr = {24'h0, chan_idx_t'(chan), sel, 2'b00};
  endfunction

  function automatic axil_data_t ref_read(input axil_addr_t addr, output axil_resp_t resp);
    int unsigned chan;
    reg_sel_t    sel;
    chan     = addr[7:4];
    sel      = addr[3:2];
    resp     = RESP_SLVERR;
    ref_read = '0;
    if (chan < NumChannels && sel != 2'd3) begin
      resp = RESP_OKAY;
      case (sel)
        REG_DUTY:   ref_read = axil_data_t'(duty_m[chan]);
        REG_PERIOD: ref_read = axil_data_t'(period_m[chan]);
        default:    ref_read = axil_data_t'(ctrl_m[chan]); // Only bit 0 survives
      endcase
    end
  endfunction

  // High cycles over k periods of PERIOD+1
  function automatic int ref_high_count(input pwm_cnt_t duty, input pwm_cnt_t period,
                                        input logic en, input int unsigned k);
    int unsigned per_len;
    per_len = int'(period) + 1;
    if (!en) return 0;
    return k * ((int'(duty) < per_len) ? int'(duty) : per_len);
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s got %0b expected %0b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // Response checker, also watches payload stability under back-pressure
  always @(posedge clk_sys) begin
    if (rst_sys_n) begin
      if (r_held) begin
        if (!rvalid) fail_run("Read response was withdrawn before rready");
        check_data("s_axil_rdata_o", rdata, r_data_h);
        check_resp("s_axil_rresp_o", rresp, r_resp_h);
      end
      if (b_held) begin
        if (!bvalid) fail_run("Write response was withdrawn before bready");
        check_resp("s_axil_bresp_o", bresp, b_resp_h);
      end
      if (rvalid && rready) begin
        if (exp_rdata_q.size() == 0) fail_run("Read response arrived with no read pending");
        check_data("s_axil_rdata_o", rdata, exp_rdata_q.pop_front());
        check_resp("s_axil_rresp_o", rresp, exp_rresp_q.pop_front());
      end
      if (bvalid && bready) begin
        if (exp_bresp_q.size() == 0) fail_run("Write response arrived with no write pending");
        check_resp("s_axil_bresp_o", bresp, exp_bresp_q.pop_front());
      end
      r_held   = rvalid && !rready;
      r_data_h = rdata;
      r_resp_h = rresp;
      b_held   = bvalid && !bready;
      b_resp_h = bresp;
    end
  end

  //////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////

  task automatic take_response(input bit is_write, input int unsigned stall);
    do @(posedge clk_sys); while (!(is_write ? bvalid : rvalid));
    repeat (stall) @(posedge clk_sys); // Back-pressure
    @(negedge clk_sys);
    bready = is_write;
    rready = !is_write;
    do @(posedge clk_sys); while (!(is_write ? (bvalid && bready) : (rvalid && rready)));
    @(negedge clk_sys);
    bready = 1'b0;
    rready = 1'b0;
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input int unsigned stall);
    axil_resp_t  exp_resp;
    int unsigned chan;
    void'(ref_read(addr, exp_resp));
    chan = addr[7:4];
    if (exp_resp == RESP_OKAY && strb[0]) begin
      case (reg_sel_t'(addr[3:2]))
        REG_DUTY:   duty_m[chan]   = data[7:0];
        REG_PERIOD: period_m[chan] = data[7:0];
        default:    ctrl_m[chan]   = data[0];
      endcase
    end
    exp_bresp_q.push_back(exp_resp);
    @(negedge clk_sys);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    do @(posedge clk_sys); while (!awready);
    check_data("s_axil_wready_o", axil_data_t'(wready), 32'h1); // Rises with awready
    @(negedge clk_sys);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    take_response(1'b1, stall);
  endtask

  task automatic axil_read(input axil_addr_t addr, input int unsigned stall);
    axil_resp_t exp_resp;
    exp_rdata_q.push_back(ref_read(addr, exp_resp));
    exp_rresp_q.push_back(exp_resp);
    @(negedge clk_sys);
    arvalid = 1'b1;
    araddr  = addr;
    do @(posedge clk_sys); while (!arready);
    @(negedge clk_sys);
    arvalid = 1'b0;
    take_response(1'b0, stall);
  endtask

  // Counts high cycles of every output over k periods of channel ch
  task automatic measure_pwm(input int unsigned ch, input int unsigned k);
    int unsigned high_cnt [NumChannels];
    int unsigned window;
    window = k * (int'(period_m[ch]) + 1);
    foreach (high_cnt[i]) high_cnt[i] = 0;
    repeat (window) begin
      @(posedge clk_sys);
      for (int i = 0; i < NumChannels; i++) begin
        if (pwm[i]) high_cnt[i]++;
      end
    end
    for (int i = 0; i < NumChannels; i++) begin
      check_count($sformatf("pwm_o[%0d] high cycles", i), high_cnt[i],
                  ref_high_count(duty_m[i], period_m[ch], ctrl_m[i], k));
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int unsigned ch;
    reg_sel_t    sel;
    void'($urandom(32'hdbe2_ab8f));
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    awaddr = '0;
    araddr = '0;
    wdata  = '0;
    wstrb  = '0;
    for (int i = 0; i < NumChannels; i++) begin
      duty_m[i]   = '0;
      period_m[i] = '0;
      ctrl_m[i]   = 1'b0;
    end
    rst_sys_n = 1'b0;
    repeat (4) @(negedge clk_sys);
    rst_sys_n = 1'b1;

    // Reset state
    check_data("pwm_o", axil_data_t'(pwm), '0);
    check_data("s_axil_bvalid_o", axil_data_t'(bvalid), '0);
    check_data("s_axil_rvalid_o", axil_data_t'(rvalid), '0);
    for (int c = 0; c < NumChannels; c++) begin
      for (int s = 0; s < 3; s++) axil_read(reg_addr(c, reg_sel_t'(s)), 0);
    end

    // Random write and readback
    for (int c = 0; c < NumChannels; c++) begin
      for (int s = 0; s < 3; s++) begin
        axil_write(reg_addr(c, reg_sel_t'(s)), $urandom(), 4'hf, 0);
        axil_read(reg_addr(c, reg_sel_t'(s)), 0);
      end
    end

    // Unmapped index and missing channel
    for (int c = 0; c < NumChannels; c++) begin
      axil_write(reg_addr(c, 2'd3), $urandom(), 4'hf, 0);
      axil_read(reg_addr(c, 2'd3), 0);
    end
    if (NumChannels < 16) begin
      axil_write(reg_addr(NumChannels, REG_DUTY), $urandom(), 4'hf, 0);
      axil_read(reg_addr(NumChannels, REG_DUTY), 0);
    end
    for (int c = 0; c < NumChannels; c++) begin
      for (int s = 0; s < 3; s++) axil_read(reg_addr(c, reg_sel_t'(s)), 0);
    end

    // Strobe bit 0 clear
    for (int c = 0; c < NumChannels; c++) begin
      axil_write(reg_addr(c, REG_DUTY), $urandom(), 4'he, 0);
      axil_read(reg_addr(c, REG_DUTY), 0);
    end

    // PWM windows, one channel enabled at a time
    for (int c = 0; c < NumChannels; c++) axil_write(reg_addr(c, REG_CTRL), '0, 4'hf, 0);
    for (int c = 0; c < NumChannels; c++) begin
      axil_write(reg_addr(c, REG_DUTY), $urandom_range(0, 255), 4'hf, 0);
      axil_write(reg_addr(c, REG_PERIOD), $urandom_range(0, 255), 4'hf, 0);
      axil_write(reg_addr(c, REG_CTRL), 32'h1, 4'hf, 0);
      measure_pwm(c, PwmPeriods);
      axil_write(reg_addr(c, REG_CTRL), '0, 4'hf, 0);
    end

    // Back-pressure on both response channels
    repeat (20) begin
      ch  = $urandom_range(0, NumChannels);
      sel = reg_sel_t'($urandom_range(0, 3));
      axil_write(reg_addr(ch, sel), $urandom(), 4'hf, $urandom_range(1, MaxStall));
      axil_read(reg_addr(ch, sel), $urandom_range(1, MaxStall));
    end

    repeat (2) @(negedge clk_sys);
    if (exp_rdata_q.size() == 0 && exp_bresp_q.size() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      fail_run("Some expected responses never arrived");
    end
  end

endmodule

`default_nettype wire

// File: sim.f
design/pwm_pkg.sv
design/pwm_reg_if.sv
design/pwm_channel.sv
design/pwm_rsp_collect.sv
design/pwm_axil_frontend.sv
design/pwm_subsystem.sv
bench/tb_pwm_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_pwm_subsystem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "TEST PASSED" || (echo "TEST FAILED"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
